/* exec_cluster.f */
rtl/exec_pkg.sv
rtl/dispatch_unit.sv
rtl/alu_lane.sv
rtl/writeback_arbiter.sv
rtl/exec_cluster.sv
testbench/exec_cluster_tb.sv

/* rtl/alu_lane.sv */
// single alu execution lane
`timescale 1ns/1ps

module alu_lane (
    input  logic                       CLK,
    input  logic                       nrst,
    input  logic                       lane_push,
    input  exec_pkg::alu_op_e          lane_op,
    input  logic [exec_pkg::DATA_W-1:0] lane_a,
    input  logic [exec_pkg::DATA_W-1:0] lane_b,
    input  logic [exec_pkg::TAG_W-1:0]  lane_tag,
    input  logic                       res_grant,
    output logic                       lane_credit,
    output logic                       res_valid,
    output logic [exec_pkg::DATA_W-1:0] res_data,
    output logic [exec_pkg::TAG_W-1:0]  res_tag
);
    import exec_pkg::*;

    // lane queue
    alu_op_e               q_op  [LANE_DEPTH];
    logic [DATA_W-1:0]     q_a   [LANE_DEPTH];
    logic [DATA_W-1:0]     q_b   [LANE_DEPTH];
    logic [TAG_W-1:0]      q_tag [LANE_DEPTH];
    logic [LANE_PTR_W-1:0] q_wr, q_rd;
    logic [LANE_CNT_W-1:0] q_cnt;

    // execute stage
    lane_state_e          state;
    logic [MUL_CNT_W-1:0] mul_cnt;
    logic [DATA_W-1:0]    ex_a, ex_b;
    logic [DATA_W-1:0]    mul_prod;
    logic                 pull;
    logic                 mul_last;
    alu_op_e              head_op;

    function automatic logic [DATA_W-1:0] alu_calc(
        input alu_op_e           op,
        input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b
    );
        case (op)
            OP_ADD:  alu_calc = a + b;
            OP_SUB:  alu_calc = a - b;
            OP_AND:  alu_calc = a & b;
            OP_OR:   alu_calc = a | b;
            OP_XOR:  alu_calc = a ^ b;
            OP_SLL:  alu_calc = a << b[4:0];
            OP_SRL:  alu_calc = a >> b[4:0];
            default: alu_calc = '0;
        endcase
    endfunction

    assign head_op = q_op[q_rd];

    // take the next op when execute is free or its result leaves this cycle
    assign pull = (q_cnt != '0) && ((state == IDLE) || (state == DONE && res_grant));

    assign lane_credit = pull;
    assign res_valid   = (state == DONE);
    assign mul_prod    = ex_a * ex_b;
    assign mul_last    = (state == BUSY) && (mul_cnt == '0);

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            q_wr    <= '0;
            q_rd    <= '0;
            q_cnt   <= '0;
            state   <= IDLE;
            mul_cnt <= '0;
        end
        else begin
            if (lane_push) begin
                q_wr <= q_wr + 1'b1;
            end
            if (pull) begin
                q_rd <= q_rd + 1'b1;
            end
            case ({lane_push, pull})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase

            if (pull) begin
                if (head_op == OP_MUL) begin
                    state   <= BUSY;
                    mul_cnt <= MUL_CNT_W'(MUL_CYCLES - 1);
                end
                else begin
                    state <= DONE;
                end
            end
            else begin
                case (state)
                    BUSY: begin
                        if (mul_cnt == '0) state <= DONE;
                        else mul_cnt <= mul_cnt - 1'b1;
                    end
                    DONE: begin
                        if (res_grant) state <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (lane_push) begin
            q_op[q_wr]  <= lane_op;
            q_a[q_wr]   <= lane_a;
            q_b[q_wr]   <= lane_b;
            q_tag[q_wr] <= lane_tag;
        end
        if (pull) begin
            ex_a    <= q_a[q_rd];
            ex_b    <= q_b[q_rd];
            res_tag <= q_tag[q_rd];
            if (head_op != OP_MUL) begin
                res_data <= alu_calc(head_op, q_a[q_rd], q_b[q_rd]);
            end
        end
        else if (mul_last) begin
            res_data <= mul_prod;
        end
    end

    a_no_push_full: assert property (@(posedge CLK) disable iff (!nrst)
        lane_push |-> q_cnt != LANE_CNT_W'(LANE_DEPTH));

    // a held result waits unchanged until the arbiter takes it
    a_res_hold: assert property (@(posedge CLK) disable iff (!nrst)
        res_valid && !res_grant |=> res_valid && $stable(res_data) && $stable(res_tag));

endmodule

/* rtl/dispatch_unit.sv */
// issue buffer and lane dispatch
`timescale 1ns/1ps

module dispatch_unit (
    input  logic                          CLK,
    input  logic                          nrst,
    input  logic                          issue_valid,
    input  exec_pkg::alu_op_e             issue_op,
    input  logic [exec_pkg::DATA_W-1:0]    issue_a,
    input  logic [exec_pkg::DATA_W-1:0]    issue_b,
    input  logic [exec_pkg::TAG_W-1:0]     issue_tag,
    input  logic [exec_pkg::NUM_LANES-1:0] lane_credit,
    output logic                          issue_credit,
    output logic [exec_pkg::NUM_LANES-1:0] lane_push,
    output exec_pkg::alu_op_e             lane_op,
    output logic [exec_pkg::DATA_W-1:0]    lane_a,
    output logic [exec_pkg::DATA_W-1:0]    lane_b,
    output logic [exec_pkg::TAG_W-1:0]     lane_tag
);
    import exec_pkg::*;

    // circular issue buffer
    alu_op_e              buf_op  [ISSUE_DEPTH];
    logic [DATA_W-1:0]    buf_a   [ISSUE_DEPTH];
    logic [DATA_W-1:0]    buf_b   [ISSUE_DEPTH];
    logic [TAG_W-1:0]     buf_tag [ISSUE_DEPTH];
    logic [ISSUE_PTR_W-1:0] wr_ptr, rd_ptr;
    logic [ISSUE_CNT_W-1:0] count;

    // per-lane credits and round-robin choice
    logic [CREDIT_W-1:0] credit_cnt [NUM_LANES];
    logic [LANE_W-1:0]   rr_ptr;
    logic [LANE_W-1:0]   cand;
    logic [LANE_W-1:0]   sel_lane;
    logic                sel_found;
    logic                pop;

    // first lane at or after rr_ptr that still has a credit
    always_comb begin
        sel_found = 1'b0;
        sel_lane  = rr_ptr;
        cand      = rr_ptr;
        for (int k = 0; k < NUM_LANES; k++) begin
            cand = LANE_W'(rr_ptr + k);
            if (!sel_found && credit_cnt[cand] != '0) begin
                sel_found = 1'b1;
                sel_lane  = cand;
            end
        end
    end

    assign pop          = (count != '0) && sel_found;
    assign issue_credit = pop;
    assign lane_push    = pop ? (NUM_LANES'(1) << sel_lane) : '0;
    assign lane_op      = buf_op[rd_ptr];
    assign lane_a       = buf_a[rd_ptr];
    assign lane_b       = buf_b[rd_ptr];
    assign lane_tag     = buf_tag[rd_ptr];

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rr_ptr <= '0;
            for (int i = 0; i < NUM_LANES; i++) begin
                credit_cnt[i] <= CREDIT_W'(LANE_DEPTH);
            end
        end
        else begin
            // pointers wrap naturally, depth is a power of two
            if (issue_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                rr_ptr <= sel_lane + 1'b1;
            end
            case ({issue_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            for (int i = 0; i < NUM_LANES; i++) begin
                credit_cnt[i] <= credit_cnt[i] - CREDIT_W'(lane_push[i])
                               + CREDIT_W'(lane_credit[i]);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_valid) begin
            buf_op[wr_ptr]  <= issue_op;
            buf_a[wr_ptr]   <= issue_a;
            buf_b[wr_ptr]   <= issue_b;
            buf_tag[wr_ptr] <= issue_tag;
        end
    end

    // issuer must hold a credit, so the buffer can never overflow
    a_no_overflow: assert property (@(posedge CLK) disable iff (!nrst)
        issue_valid |-> count != ISSUE_CNT_W'(ISSUE_DEPTH));

    a_one_push: assert property (@(posedge CLK) disable iff (!nrst)
        $onehot0(lane_push));

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_credit_chk
        a_credit_max: assert property (@(posedge CLK) disable iff (!nrst)
            credit_cnt[i] <= CREDIT_W'(LANE_DEPTH));
    end

endmodule

/* rtl/exec_cluster.sv */
// scalar execute cluster top
`timescale 1ns/1ps

module exec_cluster (
    input  logic                       CLK,
    input  logic                       nrst,
    input  logic                       issue_valid,
    input  exec_pkg::alu_op_e          issue_op,
    input  logic [exec_pkg::DATA_W-1:0] issue_a,
    input  logic [exec_pkg::DATA_W-1:0] issue_b,
    input  logic [exec_pkg::TAG_W-1:0]  issue_tag,
    output logic                       issue_credit,
    output logic                       wb_valid,
    output logic [exec_pkg::TAG_W-1:0]  wb_tag,
    output logic [exec_pkg::DATA_W-1:0] wb_data
);
    import exec_pkg::*;

    // dispatch to lanes, operands shared and qualified by lane_push
    logic [NUM_LANES-1:0] lane_push;
    logic [NUM_LANES-1:0] lane_credit;
    alu_op_e              lane_op;
    logic [DATA_W-1:0]    lane_a;
    logic [DATA_W-1:0]    lane_b;
    logic [TAG_W-1:0]     lane_tag;

    // lanes to writeback
    logic [NUM_LANES-1:0] res_valid;
    logic [NUM_LANES-1:0] res_grant;
    logic [DATA_W-1:0]    res_data [NUM_LANES];
    logic [TAG_W-1:0]     res_tag  [NUM_LANES];

    dispatch_unit u_dispatch_unit (
        .CLK          (CLK),
        .nrst         (nrst),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_tag    (issue_tag),
        .lane_credit  (lane_credit),
        .issue_credit (issue_credit),
        .lane_push    (lane_push),
        .lane_op      (lane_op),
        .lane_a       (lane_a),
        .lane_b       (lane_b),
        .lane_tag     (lane_tag)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lanes
        alu_lane u_alu_lane (
            .CLK         (CLK),
            .nrst        (nrst),
            .lane_push   (lane_push[i]),
            .lane_op     (lane_op),
            .lane_a      (lane_a),
            .lane_b      (lane_b),
            .lane_tag    (lane_tag),
            .res_grant   (res_grant[i]),
            .lane_credit (lane_credit[i]),
            .res_valid   (res_valid[i]),
            .res_data    (res_data[i]),
            .res_tag     (res_tag[i])
        );
    end

    writeback_arbiter u_writeback_arbiter (
        .CLK       (CLK),
        .nrst      (nrst),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_tag   (res_tag),
        .res_grant (res_grant),
        .wb_valid  (wb_valid),
        .wb_tag    (wb_tag),
        .wb_data   (wb_data)
    );

endmodule

/* rtl/exec_pkg.sv */
// execute cluster definitions

package exec_pkg;

    // cluster sizes
    localparam int NUM_LANES   = 4;
    localparam int LANE_DEPTH  = 2;
    localparam int ISSUE_DEPTH = 4;

    // datapath widths
    localparam int DATA_W = 32;
    localparam int TAG_W  = 6;
    localparam int OP_W   = 3;
    localparam int LANE_W = 2;

    // multiply latency in execute cycles
    localparam int MUL_CYCLES = 3;

    // derived counter and pointer widths
    localparam int ISSUE_PTR_W = $clog2(ISSUE_DEPTH);
    localparam int ISSUE_CNT_W = $clog2(ISSUE_DEPTH + 1);
    localparam int LANE_PTR_W  = $clog2(LANE_DEPTH);
    localparam int LANE_CNT_W  = $clog2(LANE_DEPTH + 1);
    localparam int CREDIT_W    = $clog2(LANE_DEPTH + 1);
    localparam int MUL_CNT_W   = $clog2(MUL_CYCLES);

    // alu opcodes
    typedef enum logic [OP_W-1:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_MUL = 3'd7
    } alu_op_e;

    // execute stage states of a lane
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUSY = 2'd1,
        DONE = 2'd2
    } lane_state_e;

endpackage

/* rtl/writeback_arbiter.sv */
// round-robin writeback arbiter
`timescale 1ns/1ps

module writeback_arbiter (
    input  logic                          CLK,
    input  logic                          nrst,
    input  logic [exec_pkg::NUM_LANES-1:0] res_valid,
    input  logic [exec_pkg::DATA_W-1:0]    res_data [exec_pkg::NUM_LANES],
    input  logic [exec_pkg::TAG_W-1:0]     res_tag  [exec_pkg::NUM_LANES],
    output logic [exec_pkg::NUM_LANES-1:0] res_grant,
    output logic                          wb_valid,
    output logic [exec_pkg::TAG_W-1:0]     wb_tag,
    output logic [exec_pkg::DATA_W-1:0]    wb_data
);
    import exec_pkg::*;

    logic [LANE_W-1:0] rr_ptr;
    logic [LANE_W-1:0] cand;
    logic [LANE_W-1:0] grant_idx;
    logic              grant_any;

    // search starts one past the last granted lane
    always_comb begin
        grant_any = 1'b0;
        grant_idx = rr_ptr;
        cand      = rr_ptr;
        for (int k = 0; k < NUM_LANES; k++) begin
            cand = LANE_W'(rr_ptr + k);
            if (!grant_any && res_valid[cand]) begin
                grant_any = 1'b1;
                grant_idx = cand;
            end
        end
    end

    assign res_grant = grant_any ? (NUM_LANES'(1) << grant_idx) : '0;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            rr_ptr   <= '0;
            wb_valid <= 1'b0;
        end
        else begin
            wb_valid <= grant_any;
            if (grant_any) begin
                rr_ptr <= grant_idx + 1'b1;
            end
        end
    end

    // result payload, qualified by wb_valid
    always_ff @(posedge CLK) begin
        if (grant_any) begin
            wb_tag  <= res_tag[grant_idx];
            wb_data <= res_data[grant_idx];
        end
    end

    a_grant_ok: assert property (@(posedge CLK) disable iff (!nrst)
        $onehot0(res_grant) && ((res_grant & ~res_valid) == '0));

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
EXE=sim_exec_cluster

rm -rf obj_dir
if ! verilator --binary --timing --assert \
        --top-module exec_cluster_tb \
        -f exec_cluster.f \
        -o "$EXE"; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qxF "All tests passed!" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, exit status $status"
exit 1

/* testbench/alu_patterns.txt */
// columns: opcode a b expected, hex; line index is the tag
// opcodes 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 mul
0 00000001 00000002 00000003
1 00000010 00000003 0000000d
7 00000003 00000005 0000000f
0 12345678 11111111 23456789
2 ff00ff00 0f0f0f0f 0f000f00
3 f0000000 0000000f f000000f
4 aaaaaaaa 55555555 ffffffff
7 00010000 00010000 00000000
5 00000001 0000001f 80000000
6 80000000 0000001f 00000001
1 00000000 00000001 ffffffff
7 ffffffff ffffffff 00000001
0 ffffffff 00000001 00000000
5 0000abcd 00000024 000abcd0
6 12345678 00000028 00123456
7 00001234 00000010 00012340
2 12345678 0000ffff 00005678
3 00ff0000 000000ff 00ff00ff
7 00000007 00000006 0000002a
0 7fffffff 00000001 80000000
4 12345678 12345678 00000000
1 80000000 00000001 7fffffff
7 0000ffff 0000ffff fffe0001
5 deadbeef 00000000 deadbeef
6 deadbeef 00000004 0deadbee
7 12345678 00000002 2468acf0
0 a5a5a5a5 5a5a5a5a ffffffff
2 ffffffff 00000000 00000000
7 00000100 00000100 00010000
1 00000005 00000007 fffffffe
3 00000000 00000000 00000000
5 00000003 00000008 00000300
7 00000003 ffffffff fffffffd
4 ffff0000 00ffff00 ff00ff00
6 ffffffff 00000010 0000ffff
0 00000100 00000200 00000300

/* testbench/exec_cluster_tb.sv */
// execute cluster testbench
`timescale 1ns/1ps

module exec_cluster_tb;
    import exec_pkg::*;

    localparam int NUM_PAT      = 36;
    localparam int BURST_START  = 18;
    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_CYCLES = 10;
    localparam int TIMEOUT      = NUM_PAT * 20 + 200;

    logic              CLK;
    logic              nrst;
    logic              issue_valid;
    alu_op_e           issue_op;
    logic [DATA_W-1:0] issue_a;
    logic [DATA_W-1:0] issue_b;
    logic [TAG_W-1:0]  issue_tag;
    logic              issue_credit;
    logic              wb_valid;
    logic [TAG_W-1:0]  wb_tag;
    logic [DATA_W-1:0] wb_data;

    // four words per pattern: opcode, a, b, expected result
    logic [31:0] pat_mem [4*NUM_PAT];
    bit          seen    [NUM_PAT];
    int          seed      = 88;
    int          spent     = 0;
    int          returned  = 0;
    int          retired   = 0;
    int          cycle_cnt = 0;

    exec_cluster u_exec_cluster (
        .CLK          (CLK),
        .nrst         (nrst),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_tag    (issue_tag),
        .issue_credit (issue_credit),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag),
        .wb_data      (wb_data)
    );

    initial CLK = 1'b0;
    always #10 CLK = ~CLK;

    // credits the issuer owns right now
    function automatic int credits_held();
        return ISSUE_DEPTH + returned - spent;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_quiet();
        assert (wb_valid == 1'b0) else
            stop_run($sformatf("[FAIL] t=%0t wb_valid: expected 0 got %b", $time, wb_valid));
        assert (issue_credit == 1'b0) else
            stop_run($sformatf("[FAIL] t=%0t issue_credit: expected 0 got %b",
                               $time, issue_credit));
    endtask

    always @(posedge CLK) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            stop_run($sformatf("timeout after %0d cycles, only %0d of %0d results retired",
                               cycle_cnt, retired, NUM_PAT));
        end
    end

    // credit return and writeback monitor, mid-cycle
    always @(negedge CLK) begin
        int                tag_idx;
        logic [DATA_W-1:0] exp_val;
        if (nrst) begin
            if (issue_credit) begin
                returned = returned + 1;
            end
            assert (credits_held() <= ISSUE_DEPTH) else
                stop_run($sformatf("issuer holds %0d credits at t=%0t, more than %0d",
                                   credits_held(), $time, ISSUE_DEPTH));
            if (wb_valid) begin
                tag_idx = int'(wb_tag);
                assert (tag_idx < spent) else
                    stop_run($sformatf("[FAIL] t=%0t wb_tag: expected below %0d got %0d",
                                       $time, spent, tag_idx));
                assert (!seen[tag_idx]) else
                    stop_run($sformatf("tag %0d retired a second time at t=%0t",
                                       tag_idx, $time));
                exp_val = pat_mem[4*tag_idx+3];
                assert (wb_data == exp_val) else
                    stop_run($sformatf("[FAIL] t=%0t wb_data (tag %0d): expected %h got %h",
                                       $time, tag_idx, exp_val, wb_data));
                seen[tag_idx] = 1'b1;
                retired = retired + 1;
            end
        end
    end

    initial begin
        int gap;
        nrst        = 1'b0;
        issue_valid = 1'b0;
        issue_op    = OP_ADD;
        issue_a     = '0;
        issue_b     = '0;
        issue_tag   = '0;

        // opcode words above 7 mark lines the file did not supply
        for (int k = 0; k < 4*NUM_PAT; k++) begin
            pat_mem[k] = 32'hdead0000 | 32'(k);
        end
        $readmemh("testbench/alu_patterns.txt", pat_mem);
        for (int k = 0; k < NUM_PAT; k++) begin
            assert (pat_mem[4*k] < 32'd8) else
                stop_run($sformatf("pattern file has no valid opcode for line %0d", k));
        end

        repeat (RESET_CYCLES) begin
            @(posedge CLK);
            @(negedge CLK);
            check_quiet();
        end
        @(posedge CLK);
        nrst <= 1'b1;
        @(negedge CLK);
        check_quiet();

        // spaced issue first, then back to back to hit the stall path
        @(posedge CLK);
        for (int i = 0; i < NUM_PAT; i++) begin
            if (i < BURST_START) begin
                gap = $random(seed) & 3;
                issue_valid <= 1'b0;
                repeat (gap) @(posedge CLK);
            end
            while (credits_held() == 0) begin
                issue_valid <= 1'b0;
                @(posedge CLK);
            end
            issue_valid <= 1'b1;
            issue_op    <= alu_op_e'(pat_mem[4*i][OP_W-1:0]);
            issue_a     <= pat_mem[4*i+1];
            issue_b     <= pat_mem[4*i+2];
            issue_tag   <= TAG_W'(i);
            spent = spent + 1;
            @(posedge CLK);
        end
        issue_valid <= 1'b0;

        while (retired < NUM_PAT) begin
            @(posedge CLK);
        end
        repeat (DRAIN_CYCLES) @(posedge CLK);
        assert (credits_held() == ISSUE_DEPTH) else
            stop_run($sformatf("issuer holds %0d credits after drain, expected %0d",
                               credits_held(), ISSUE_DEPTH));
        $display("All tests passed!");
        $finish;
    end

endmodule
